//--- common/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// data word width
`define ID_XLEN 32

// register number width, 32 registers
`define ID_REG_AW 5

// source operands per instruction, rs and rt
`define ID_NUM_SRC 2

// written by jal, bltzal and bgezal
`define ID_LINK_REG 31

`endif

//--- common/id_pkg.sv
`default_nettype none

`include "id_config.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] word_t;

    typedef logic [`ID_REG_AW-1:0] reg_addr_t;

    // one-hot, lsb first:
    // add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_op_t;

    // one-hot, msb first: lb lbu lh lhu lw
    typedef logic [4:0] load_op_t;

    // one-hot, msb first: sb sh sw
    typedef logic [2:0] store_op_t;

    // first alu operand
    typedef enum logic [1:0] {
        SRC1_REG = 2'd0,
        SRC1_SA  = 2'd1,
        SRC1_PC  = 2'd2
    } src1_sel_t;

    // second alu operand, eight is the link offset past the delay slot
    typedef enum logic [1:0] {
        SRC2_REG   = 2'd0,
        SRC2_SIMM  = 2'd1,
        SRC2_ZIMM  = 2'd2,
        SRC2_EIGHT = 2'd3
    } src2_sel_t;

endpackage

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_config.svh"

module regfile (
    input  wire                clk,
    input  wire id_pkg::reg_addr_t raddr1,
    input  wire id_pkg::reg_addr_t raddr2,
    input  wire id_pkg::reg_addr_t waddr,
    input  wire                we,
    input  wire id_pkg::word_t wdata,
    output id_pkg::word_t      rdata1,
    output id_pkg::word_t      rdata2
);

    id_pkg::word_t rf [0:(1 << `ID_REG_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired, whatever was stored there
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

    a_r0_zero: assert property (@(posedge clk)
        (we && waddr == '0) |=> ((raddr1 != '0) || (rdata1 == '0)) &&
                                ((raddr2 != '0) || (rdata2 == '0)))
        else $error("register 0 read nonzero after a write to it");

endmodule

`default_nettype wire

//--- id_stage/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_config.svh"

module inst_decoder (
    input  wire id_pkg::word_t    inst,
    output id_pkg::alu_op_t       alu_op,
    output id_pkg::load_op_t      load_op,
    output id_pkg::store_op_t     store_op,
    output id_pkg::src1_sel_t     src1_sel,
    output id_pkg::src2_sel_t     src2_sel,
    output logic                  gr_we,
    output logic                  mem_we,
    output id_pkg::reg_addr_t     dest,
    output logic [15:0]           imm,
    output id_pkg::reg_addr_t     rs,
    output id_pkg::reg_addr_t     rt,
    output logic [`ID_NUM_SRC-1:0] src_need,
    output logic [7:0]            br_kind
);

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] rd;
    logic [4:0] sa;
    logic       r_type;
    logic       sh_type;
    logic       regimm;
    logic       i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic       i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav, i_jr, i_jalr;
    logic       i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic       i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz;
    logic       i_bltzal, i_bgezal, i_j, i_jal;
    logic       is_alu_r;
    logic       is_alu_i;
    logic       is_link;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];

    // special opcode, sa must be zero except for the constant shifts
    assign r_type  = (op == 6'h00) && (sa == 5'h00);
    assign sh_type = (op == 6'h00) && (rs == 5'h00);
    assign regimm  = (op == 6'h01);

    assign i_addu = r_type && (func == 6'h21);
    assign i_subu = r_type && (func == 6'h23);
    assign i_slt  = r_type && (func == 6'h2a);
    assign i_sltu = r_type && (func == 6'h2b);
    assign i_and  = r_type && (func == 6'h24);
    assign i_or   = r_type && (func == 6'h25);
    assign i_xor  = r_type && (func == 6'h26);
    assign i_nor  = r_type && (func == 6'h27);
    assign i_sllv = r_type && (func == 6'h04);
    assign i_srlv = r_type && (func == 6'h06);
    assign i_srav = r_type && (func == 6'h07);
    assign i_sll  = sh_type && (func == 6'h00);
    assign i_srl  = sh_type && (func == 6'h02);
    assign i_sra  = sh_type && (func == 6'h03);
    assign i_jr   = r_type && (func == 6'h08) && (rt == 5'h00) && (rd == 5'h00);
    assign i_jalr = r_type && (func == 6'h09) && (rt == 5'h00);

    assign i_addiu = (op == 6'h09);
    assign i_slti  = (op == 6'h0a);
    assign i_sltiu = (op == 6'h0b);
    assign i_andi  = (op == 6'h0c);
    assign i_ori   = (op == 6'h0d);
    assign i_xori  = (op == 6'h0e);
    assign i_lui   = (op == 6'h0f) && (rs == 5'h00);

    assign i_beq    = (op == 6'h04);
    assign i_bne    = (op == 6'h05);
    assign i_blez   = (op == 6'h06) && (rt == 5'h00);
    assign i_bgtz   = (op == 6'h07) && (rt == 5'h00);
    assign i_bltz   = regimm && (rt == 5'h00);
    assign i_bgez   = regimm && (rt == 5'h01);
    assign i_bltzal = regimm && (rt == 5'h10);
    assign i_bgezal = regimm && (rt == 5'h11);
    assign i_j      = (op == 6'h02);
    assign i_jal    = (op == 6'h03);

    assign load_op  = {op == 6'h20, op == 6'h24, op == 6'h21, op == 6'h25, op == 6'h23};
    assign store_op = {op == 6'h28, op == 6'h29, op == 6'h2b};

    assign is_alu_r = i_addu | i_subu | i_slt | i_sltu | i_and | i_or | i_xor | i_nor |
                      i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;
    assign is_alu_i = i_addiu | i_slti | i_sltiu | i_andi | i_ori | i_xori | i_lui;
    assign is_link  = i_jal | i_bltzal | i_bgezal | i_jalr;

    assign alu_op = {i_lui, i_sra | i_srav, i_srl | i_srlv, i_sll | i_sllv,
                     i_xor | i_xori, i_or | i_ori, i_nor, i_and | i_andi,
                     i_sltu | i_sltiu, i_slt | i_slti, i_subu,
                     i_addu | i_addiu | (|load_op) | (|store_op) | is_link};

    assign gr_we  = is_alu_r | is_alu_i | (|load_op) | is_link;
    assign mem_we = |store_op;

    assign br_kind = {i_jr | i_jalr, i_j | i_jal, i_bltz | i_bltzal, i_blez,
                      i_bgtz, i_bgez | i_bgezal, i_bne, i_beq};

    // rs: everything but the constant shifts, lui, j and jal
    assign src_need[0] = (is_alu_r & ~(i_sll | i_srl | i_sra)) | (is_alu_i & ~i_lui) |
                         (|load_op) | (|store_op) | (|br_kind[5:0]) | br_kind[7];
    assign src_need[1] = is_alu_r | (|store_op) | i_beq | i_bne;

    always_comb begin
        if (!gr_we) begin
            dest = '0;
        end else if (i_jal | i_bltzal | i_bgezal) begin
            dest = id_pkg::reg_addr_t'(`ID_LINK_REG);
        end else if (is_alu_i | (|load_op)) begin
            dest = rt;
        end else begin
            dest = rd;
        end
    end

    always_comb begin
        src1_sel = id_pkg::SRC1_REG;
        if (i_sll | i_srl | i_sra) begin
            src1_sel = id_pkg::SRC1_SA;
        end else if (is_link) begin
            src1_sel = id_pkg::SRC1_PC;
        end
    end

    always_comb begin
        src2_sel = id_pkg::SRC2_REG;
        if (i_andi | i_ori | i_xori) begin
            src2_sel = id_pkg::SRC2_ZIMM;
        end else if (is_alu_i | (|load_op) | (|store_op)) begin
            src2_sel = id_pkg::SRC2_SIMM;
        end else if (is_link) begin
            src2_sel = id_pkg::SRC2_EIGHT;
        end
    end

endmodule

`default_nettype wire

//--- id_stage/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
    input  wire                    ds_valid,
    input  wire                    need,
    input  wire id_pkg::reg_addr_t src_addr,
    input  wire id_pkg::word_t     rf_data,
    input  wire                    es_valid,
    input  wire                    es_gr_we,
    input  wire id_pkg::reg_addr_t es_dest,
    input  wire id_pkg::word_t     es_result,
    input  wire                    es_load,
    input  wire                    ms_valid,
    input  wire                    ms_gr_we,
    input  wire id_pkg::reg_addr_t ms_dest,
    input  wire id_pkg::word_t     ms_result,
    input  wire                    ms_load,
    input  wire                    ms_res_valid,
    input  wire                    ws_we,
    input  wire id_pkg::reg_addr_t ws_dest,
    input  wire id_pkg::word_t     ws_result,
    output id_pkg::word_t          value,
    output logic                   block
);

    logic lookup;
    logic es_hit;
    logic ms_hit;
    logic ws_hit;

    // r0 never forwards
    assign lookup = ds_valid && need && (src_addr != '0);

    assign es_hit = lookup && es_valid && es_gr_we && (es_dest == src_addr);
    assign ms_hit = lookup && ms_valid && ms_gr_we && (ms_dest == src_addr);
    assign ws_hit = lookup && ws_we && (ws_dest == src_addr);

    // youngest producer first
    assign value = es_hit ? es_result :
                   ms_hit ? ms_result :
                   ws_hit ? ws_result :
                            rf_data;

    // load data not back yet
    assign block = (es_hit && es_load) || (ms_hit && ms_load && !ms_res_valid);

    always_comb begin
        if (block) begin
            a_block_hit: assert (es_hit || ms_hit)
                else $error("operand blocked with no execute or memory match");
        end
    end

endmodule

`default_nettype wire

//--- id_stage/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_config.svh"

// br_kind bits, lsb first: eq ne gez gtz lez ltz jump jump-register
module branch_unit (
    input  wire                      ds_valid,
    input  wire [7:0]                br_kind,
    input  wire id_pkg::word_t       pc,
    input  wire [15:0]               imm,
    input  wire [25:0]               jidx,
    input  wire id_pkg::word_t       rs_value,
    input  wire id_pkg::word_t       rt_value,
    input  wire [`ID_NUM_SRC-1:0]    src_block,
    output logic                     br_taken,
    output id_pkg::word_t            br_target,
    output logic                     br_stall
);

    id_pkg::word_t bd_pc;
    id_pkg::word_t br_offset;
    logic          rs_eq_rt;
    logic          rs_ge_z;
    logic          rs_gt_z;
    logic          cond_taken;

    assign bd_pc     = pc + id_pkg::word_t'(4);
    assign br_offset = {{(`ID_XLEN-18){imm[15]}}, imm, 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ge_z  = !rs_value[`ID_XLEN-1];
    assign rs_gt_z  = rs_ge_z && (rs_value != '0);

    assign cond_taken = (br_kind[0] &&  rs_eq_rt) ||
                        (br_kind[1] && !rs_eq_rt) ||
                        (br_kind[2] &&  rs_ge_z)  ||
                        (br_kind[3] &&  rs_gt_z)  ||
                        (br_kind[4] && !rs_gt_z)  ||
                        (br_kind[5] && !rs_ge_z);

    assign br_taken = ds_valid && (cond_taken || br_kind[6] || br_kind[7]);

    always_comb begin
        if (|br_kind[5:0]) begin
            br_target = bd_pc + br_offset;
        end else if (br_kind[7]) begin
            br_target = rs_value;
        end else begin
            // region of the delay slot
            br_target = {bd_pc[`ID_XLEN-1:`ID_XLEN-4], jidx, 2'b00};
        end
    end

    // fetch must wait, the compare inputs are not final
    assign br_stall = ds_valid && (|br_kind) && (|src_block);

endmodule

`default_nettype wire

//--- id_stage/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_config.svh"

module id_stage (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    fs_to_ds_valid,
    input  wire id_pkg::word_t     fs_inst,
    input  wire id_pkg::word_t     fs_pc,
    input  wire                    es_allowin,
    input  wire                    es_valid,
    input  wire                    es_gr_we,
    input  wire id_pkg::reg_addr_t es_dest,
    input  wire id_pkg::word_t     es_result,
    input  wire                    es_load,
    input  wire                    ms_valid,
    input  wire                    ms_gr_we,
    input  wire id_pkg::reg_addr_t ms_dest,
    input  wire id_pkg::word_t     ms_result,
    input  wire                    ms_load,
    input  wire                    ms_res_valid,
    input  wire                    ws_we,
    input  wire id_pkg::reg_addr_t ws_dest,
    input  wire id_pkg::word_t     ws_result,
    output logic                   ds_allowin,
    output logic                   ds_to_es_valid,
    output id_pkg::alu_op_t        ds_alu_op,
    output id_pkg::load_op_t       ds_load_op,
    output id_pkg::store_op_t      ds_store_op,
    output id_pkg::src1_sel_t      ds_src1_sel,
    output id_pkg::src2_sel_t      ds_src2_sel,
    output logic                   ds_gr_we,
    output logic                   ds_mem_we,
    output id_pkg::reg_addr_t      ds_dest,
    output logic [15:0]            ds_imm,
    output id_pkg::word_t          ds_rs_value,
    output id_pkg::word_t          ds_rt_value,
    output id_pkg::word_t          ds_pc,
    output logic                   br_taken,
    output logic                   br_stall,
    output id_pkg::word_t          br_target
);

    logic                    ds_valid;
    logic                    ready_go;
    id_pkg::word_t           ds_inst;
    id_pkg::reg_addr_t       rs;
    id_pkg::reg_addr_t       rt;
    logic [`ID_NUM_SRC-1:0]  src_need;
    logic [`ID_NUM_SRC-1:0]  src_block;
    logic [7:0]              br_kind;
    id_pkg::reg_addr_t       src_addr  [`ID_NUM_SRC];
    id_pkg::word_t           rf_data   [`ID_NUM_SRC];
    id_pkg::word_t           src_value [`ID_NUM_SRC];

    assign ready_go       = !(|src_block);
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_inst_decoder (
        .inst     (ds_inst),
        .alu_op   (ds_alu_op),
        .load_op  (ds_load_op),
        .store_op (ds_store_op),
        .src1_sel (ds_src1_sel),
        .src2_sel (ds_src2_sel),
        .gr_we    (ds_gr_we),
        .mem_we   (ds_mem_we),
        .dest     (ds_dest),
        .imm      (ds_imm),
        .rs       (rs),
        .rt       (rt),
        .src_need (src_need),
        .br_kind  (br_kind)
    );

    // port 1 reads rs, port 2 reads rt
    assign src_addr[0] = rs;
    assign src_addr[1] = rt;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (src_addr[0]),
        .raddr2 (src_addr[1]),
        .waddr  (ws_dest),
        .we     (ws_we),
        .wdata  (ws_result),
        .rdata1 (rf_data[0]),
        .rdata2 (rf_data[1])
    );

    for (genvar i = 0; i < `ID_NUM_SRC; i++) begin : g_src
        operand_bypass u_operand_bypass (
            .ds_valid     (ds_valid),
            .need         (src_need[i]),
            .src_addr     (src_addr[i]),
            .rf_data      (rf_data[i]),
            .es_valid     (es_valid),
            .es_gr_we     (es_gr_we),
            .es_dest      (es_dest),
            .es_result    (es_result),
            .es_load      (es_load),
            .ms_valid     (ms_valid),
            .ms_gr_we     (ms_gr_we),
            .ms_dest      (ms_dest),
            .ms_result    (ms_result),
            .ms_load      (ms_load),
            .ms_res_valid (ms_res_valid),
            .ws_we        (ws_we),
            .ws_dest      (ws_dest),
            .ws_result    (ws_result),
            .value        (src_value[i]),
            .block        (src_block[i])
        );
    end

    assign ds_rs_value = src_value[0];
    assign ds_rt_value = src_value[1];

    branch_unit u_branch_unit (
        .ds_valid  (ds_valid),
        .br_kind   (br_kind),
        .pc        (ds_pc),
        .imm       (ds_imm),
        .jidx      (ds_inst[25:0]),
        .rs_value  (ds_rs_value),
        .rt_value  (ds_rt_value),
        .src_block (src_block),
        .br_taken  (br_taken),
        .br_target (br_target),
        .br_stall  (br_stall)
    );

    a_out_valid: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid)
        else $error("ds_to_es_valid without a held instruction");

endmodule

`default_nettype wire

//--- dv/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// mirror of the register file and the stage register
id_pkg::word_t     m_rf [0:31];
logic              m_valid;
id_pkg::word_t     m_inst;
id_pkg::word_t     m_pc;

// expected decode
id_pkg::alu_op_t   e_alu;
id_pkg::load_op_t  e_load;
id_pkg::store_op_t e_store;
logic [1:0]        e_src1;
logic [1:0]        e_src2;
logic              e_gr_we;
logic              e_mem_we;
id_pkg::reg_addr_t e_dest;
logic              e_need_rs;
logic              e_need_rt;
// 0 none, 1 beq, 2 bne, 3 bgez, 4 bgtz, 5 blez, 6 bltz, 7 j, 8 jr
int                e_bk;

task automatic set_link(input id_pkg::reg_addr_t d);
    e_alu   = 12'b1;
    e_src1  = 2'd2;
    e_src2  = 2'd3;
    e_gr_we = 1'b1;
    e_dest  = d;
endtask

task automatic model_decode(input id_pkg::word_t inst);
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] fn;
    int         idx;
    op = inst[31:26];
    rs = inst[25:21];
    rt = inst[20:16];
    rd = inst[15:11];
    sa = inst[10:6];
    fn = inst[5:0];
    e_alu = '0;
    e_load = '0;
    e_store = '0;
    e_src1 = 2'd0;
    e_src2 = 2'd0;
    e_gr_we = 1'b0;
    e_mem_we = 1'b0;
    e_dest = '0;
    e_need_rs = 1'b0;
    e_need_rt = 1'b0;
    e_bk = 0;
    idx = -1;
    if (op == 6'h00) begin
        if (rs == 5'd0 && (fn == 6'h00 || fn == 6'h02 || fn == 6'h03)) begin
            e_alu = 12'b1 << (fn == 6'h00 ? 8 : (fn == 6'h02 ? 9 : 10));
            e_src1 = 2'd1;
            e_gr_we = 1'b1;
            e_dest = rd;
            e_need_rt = 1'b1;
        end else if (sa == 5'd0) begin
            case (fn)
                6'h21: idx = 0;
                6'h23: idx = 1;
                6'h2a: idx = 2;
                6'h2b: idx = 3;
                6'h24: idx = 4;
                6'h27: idx = 5;
                6'h25: idx = 6;
                6'h26: idx = 7;
                6'h04: idx = 8;
                6'h06: idx = 9;
                6'h07: idx = 10;
                6'h08: if (rt == 5'd0 && rd == 5'd0) begin
                    e_need_rs = 1'b1;
                    e_bk = 8;
                end
                6'h09: if (rt == 5'd0) begin
                    set_link(rd);
                    e_need_rs = 1'b1;
                    e_bk = 8;
                end
                default: ;
            endcase
            if (idx >= 0) begin
                e_alu = 12'b1 << idx;
                e_gr_we = 1'b1;
                e_dest = rd;
                e_need_rs = 1'b1;
                e_need_rt = 1'b1;
            end
        end
    end else if (op >= 6'h09 && op <= 6'h0e) begin
        case (op)
            6'h09: idx = 0;
            6'h0a: idx = 2;
            6'h0b: idx = 3;
            6'h0c: idx = 4;
            6'h0d: idx = 6;
            default: idx = 7;
        endcase
        e_alu = 12'b1 << idx;
        e_src2 = (op >= 6'h0c) ? 2'd2 : 2'd1;
        e_gr_we = 1'b1;
        e_dest = rt;
        e_need_rs = 1'b1;
    end else if (op == 6'h0f && rs == 5'd0) begin
        e_alu = 12'b1 << 11;
        e_src2 = 2'd1;
        e_gr_we = 1'b1;
        e_dest = rt;
    end else if (op == 6'h20 || op == 6'h24 || op == 6'h21 || op == 6'h25 ||
                 op == 6'h23) begin
        // lb lbu lh lhu lw from msb down
        e_load = (op == 6'h20) ? 5'b10000 : (op == 6'h24) ? 5'b01000 :
                 (op == 6'h21) ? 5'b00100 : (op == 6'h25) ? 5'b00010 : 5'b00001;
        e_alu = 12'b1;
        e_src2 = 2'd1;
        e_gr_we = 1'b1;
        e_dest = rt;
        e_need_rs = 1'b1;
    end else if (op == 6'h28 || op == 6'h29 || op == 6'h2b) begin
        e_store = (op == 6'h28) ? 3'b100 : (op == 6'h29) ? 3'b010 : 3'b001;
        e_alu = 12'b1;
        e_src2 = 2'd1;
        e_mem_we = 1'b1;
        e_need_rs = 1'b1;
        e_need_rt = 1'b1;
    end else if (op == 6'h04 || op == 6'h05) begin
        e_bk = (op == 6'h04) ? 1 : 2;
        e_need_rs = 1'b1;
        e_need_rt = 1'b1;
    end else if ((op == 6'h06 || op == 6'h07) && rt == 5'd0) begin
        e_bk = (op == 6'h06) ? 5 : 4;
        e_need_rs = 1'b1;
    end else if (op == 6'h01 && (rt == 5'h00 || rt == 5'h01 || rt == 5'h10 ||
                                 rt == 5'h11)) begin
        e_bk = rt[0] ? 3 : 6;
        e_need_rs = 1'b1;
        if (rt[4]) begin
            set_link(5'd31);
        end
    end else if (op == 6'h02 || op == 6'h03) begin
        e_bk = 7;
        if (op == 6'h03) begin
            set_link(5'd31);
        end
    end
endtask

task automatic model_operand(input id_pkg::reg_addr_t a, input logic need,
                             output id_pkg::word_t v, output logic blk);
    logic look;
    logic he;
    logic hm;
    logic hw;
    look = m_valid && need && (a != 5'd0);
    he = look && es_valid && es_gr_we && (es_dest == a);
    hm = look && ms_valid && ms_gr_we && (ms_dest == a);
    hw = look && ws_we && (ws_dest == a);
    v = he ? es_result : hm ? ms_result : hw ? ws_result : m_rf[a];
    blk = (he && es_load) || (hm && ms_load && !ms_res_valid);
endtask

task automatic model_branch(input id_pkg::word_t rsv, input id_pkg::word_t rtv,
                            input logic any_blk, output logic taken,
                            output id_pkg::word_t target, output logic stall);
    id_pkg::word_t slot_pc;
    logic          cond;
    slot_pc = m_pc + 32'd4;
    case (e_bk)
        1: cond = (rsv == rtv);
        2: cond = (rsv != rtv);
        3: cond = ($signed(rsv) >= 0);
        4: cond = ($signed(rsv) > 0);
        5: cond = ($signed(rsv) <= 0);
        6: cond = ($signed(rsv) < 0);
        7, 8: cond = 1'b1;
        default: cond = 1'b0;
    endcase
    taken = m_valid && cond;
    if (e_bk == 8) begin
        target = rsv;
    end else if (e_bk == 7) begin
        target = {slot_pc[31:28], m_inst[25:0], 2'b00};
    end else begin
        target = slot_pc + {{14{m_inst[15]}}, m_inst[15:0], 2'b00};
    end
    stall = m_valid && (e_bk != 0) && any_blk;
endtask

`endif

//--- dv/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;

    localparam int PERIOD    = 20;
    localparam int NUM_TESTS = 2000;
    localparam int PRELOAD   = 32;

    integer seed = 84246;

    logic clk, reset, fs_to_ds_valid, es_allowin;
    id_pkg::word_t fs_inst, fs_pc, es_result, ms_result, ws_result;
    logic es_valid, es_gr_we, es_load, ms_valid, ms_gr_we, ms_load, ms_res_valid, ws_we;
    id_pkg::reg_addr_t es_dest, ms_dest, ws_dest;
    logic ds_allowin, ds_to_es_valid, ds_gr_we, ds_mem_we, br_taken, br_stall;
    id_pkg::alu_op_t   ds_alu_op;
    id_pkg::load_op_t  ds_load_op;
    id_pkg::store_op_t ds_store_op;
    id_pkg::src1_sel_t ds_src1_sel;
    id_pkg::src2_sel_t ds_src2_sel;
    id_pkg::reg_addr_t ds_dest;
    logic [15:0]       ds_imm;
    id_pkg::word_t     ds_rs_value, ds_rt_value, ds_pc, br_target;

    id_pkg::word_t v_rs, v_rt, e_target;
    logic b_rs, b_rt, e_taken, e_stall, exp_allowin;

    `include "id_ref_model.svh"

    id_stage u_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(longint'(NUM_TESTS) * 10 * PERIOD);
        $display("timeout: the test loop did not finish in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    task automatic report_error(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input id_pkg::word_t got,
                              input id_pkg::word_t exp);
        if (got !== exp) report_error(what, got, exp);
    endtask

    task automatic check_reg(input string what, input id_pkg::reg_addr_t got,
                             input id_pkg::reg_addr_t exp);
        if (got !== exp) report_error(what, 32'(got), 32'(exp));
    endtask

    task automatic check_alu(input id_pkg::alu_op_t got, input id_pkg::alu_op_t exp);
        if (got !== exp) report_error("ds_alu_op", 32'(got), 32'(exp));
    endtask

    task automatic check_mem_op(input id_pkg::load_op_t ld, input id_pkg::load_op_t e_ld,
                                input id_pkg::store_op_t st, input id_pkg::store_op_t e_st);
        if (ld !== e_ld) report_error("ds_load_op", 32'(ld), 32'(e_ld));
        if (st !== e_st) report_error("ds_store_op", 32'(st), 32'(e_st));
    endtask

    task automatic check_sel(input string what, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) report_error(what, 32'(got), 32'(exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) report_error(what, 32'(got), 32'(exp));
    endtask

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic id_pkg::word_t enc_r(input int rs, input int rt, input int rd,
                                            input int sa, input logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic id_pkg::word_t enc_i(input logic [5:0] op, input int rs, input int rt);
        return {op, 5'(rs), 5'(rt), 16'($random(seed))};
    endfunction

    // registers 0..7 to make forwarding hits frequent
    function automatic id_pkg::word_t random_inst();
        int k;
        int rs;
        int rt;
        int rd;
        logic [5:0] r_fn [0:10];
        logic [5:0] mem_op [0:7];
        r_fn = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07};
        mem_op = '{6'h23, 6'h20, 6'h24, 6'h21, 6'h25, 6'h2b, 6'h28, 6'h29};
        k = rnd(44);
        rs = rnd(8);
        rt = rnd(8);
        rd = rnd(8);
        if (k <= 10) return enc_r(rs, rt, rd, 0, r_fn[k]);
        if (k <= 13) return enc_r(0, rt, rd, rnd(32), (k == 11) ? 6'h00 : 6'(k - 10));
        if (k == 14) return enc_r(rs, 0, 0, 0, 6'h08);
        if (k == 15) return enc_r(rs, 0, rd, 0, 6'h09);
        if (k <= 21) return enc_i(6'(k - 7), rs, rt);
        if (k == 22) return enc_i(6'h0f, 0, rt);
        if (k <= 30) return enc_i(mem_op[k - 23], rs, rt);
        if (k <= 34) return enc_i(6'(k - 27), rs, (k >= 33) ? 0 : rt);
        if (k <= 38) return enc_i(6'h01, rs, (k == 35) ? 0 : (k == 36) ? 1 : (k == 37) ? 16 : 17);
        if (k <= 40) return {6'(k - 37), 26'($random(seed))};
        return $random(seed);
    endfunction

    task automatic drive_inputs(input logic preload, input int idx);
        fs_to_ds_valid = !preload && (rnd(4) != 0);
        fs_inst = random_inst();
        fs_pc = {$random(seed)} & 32'hffff_fffc;
        es_allowin = (rnd(4) != 0);
        es_valid = rnd(2);
        es_gr_we = rnd(2);
        es_dest = 5'(rnd(8));
        es_result = $random(seed);
        es_load = (rnd(3) == 0);
        ms_valid = rnd(2);
        ms_gr_we = rnd(2);
        ms_dest = 5'(rnd(8));
        ms_result = $random(seed);
        ms_load = (rnd(3) == 0);
        ms_res_valid = rnd(2);
        ws_we = preload ? 1'b1 : rnd(2);
        ws_dest = preload ? 5'(idx) : 5'(rnd(8));
        ws_result = $random(seed);
    endtask

    task automatic run_checks();
        model_decode(m_inst);
        model_operand(m_inst[25:21], e_need_rs, v_rs, b_rs);
        model_operand(m_inst[20:16], e_need_rt, v_rt, b_rt);
        exp_allowin = !m_valid || (!(b_rs || b_rt) && es_allowin);
        model_branch(v_rs, v_rt, b_rs || b_rt, e_taken, e_target, e_stall);
        check_flag("ds_allowin", ds_allowin, exp_allowin);
        check_flag("ds_to_es_valid", ds_to_es_valid, m_valid && !(b_rs || b_rt));
        check_flag("br_taken", br_taken, e_taken);
        check_flag("br_stall", br_stall, e_stall);
        if (m_valid && e_bk != 0) check_word("br_target", br_target, e_target);
        if (m_valid) begin
            check_alu(ds_alu_op, e_alu);
            check_mem_op(ds_load_op, e_load, ds_store_op, e_store);
            check_sel("ds_src1_sel", ds_src1_sel, e_src1);
            check_sel("ds_src2_sel", ds_src2_sel, e_src2);
            check_flag("ds_gr_we", ds_gr_we, e_gr_we);
            check_flag("ds_mem_we", ds_mem_we, e_mem_we);
            check_reg("ds_dest", ds_dest, e_dest);
            check_word("ds_imm", 32'(ds_imm), 32'(m_inst[15:0]));
            check_word("ds_rs_value", ds_rs_value, v_rs);
            check_word("ds_rt_value", ds_rt_value, v_rt);
            check_word("ds_pc", ds_pc, m_pc);
        end
    endtask

    task automatic update_model();
        if (exp_allowin) m_valid = fs_to_ds_valid;
        if (fs_to_ds_valid && exp_allowin) begin
            m_inst = fs_inst;
            m_pc = fs_pc;
        end
        if (ws_we && ws_dest != 5'd0) m_rf[ws_dest] = ws_result;
    endtask

    initial begin
        reset = 1'b1;
        drive_inputs(1'b1, 0);
        ws_we = 1'b0;
        m_valid = 1'b0;
        m_rf[0] = '0;
        repeat (4) @(posedge clk);
        // preload every register, then random traffic
        for (int c = 0; c < PRELOAD + NUM_TESTS; c++) begin
            #2;
            reset = 1'b0;
            drive_inputs(c < PRELOAD, c);
            #10;
            run_checks();
            @(posedge clk);
            update_model();
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
+incdir+dv
common/id_pkg.sv
logic/regfile.sv
id_stage/inst_decoder.sv
id_stage/operand_bypass.sv
id_stage/branch_unit.sv
id_stage/id_stage.sv
dv/tb_id_stage.sv

//--- run.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_id_stage \
    -o sim_id_stage > build.log 2>&1 &&
./obj_dir/sim_id_stage > sim.log 2>&1
grep -q "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
